/* design/otter_mem_pkg.sv */
package otter_mem_pkg;

    //////////////////////////////////////////////////////////////////////
    // Memory geometry
    //////////////////////////////////////////////////////////////////////

    // Total capacity of the shared SRAM
    localparam int MEM_SIZE_BYTES = 32768;

    // Byte address bits that index the SRAM
    localparam int MEM_ADDR_WIDTH = $clog2(MEM_SIZE_BYTES);

    // Word count, four bytes per word
    localparam int MEM_NUM_WORDS = MEM_SIZE_BYTES / 4;

    // Data path width on both ports
    localparam int DATA_WIDTH = 32;

    // Full AXI address width, upper bits select the window
    localparam int AXI_ADDR_WIDTH = 32;

    //////////////////////////////////////////////////////////////////////
    // AXI4-Lite types
    //////////////////////////////////////////////////////////////////////

    // Response codes, EXOKAY and DECERR never produced here
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axi_resp_e;

    // Slave FSM, one transaction in flight at a time
    typedef enum logic [2:0] {
        st_idle,
        st_read,
        st_write,
        st_rresp,
        st_bresp
    } axil_state_e;

endpackage

/* design/sram.sv */
`timescale 1ns/10ps

module sram (
    input  logic                                    A_clk,
    input  logic                                    rst_n,

    // Port A, read only
    input  logic                                    a_read,
    input  logic [otter_mem_pkg::MEM_ADDR_WIDTH-1:0] a_addr,
    output logic [otter_mem_pkg::DATA_WIDTH-1:0]     a_rdata,
    output logic                                    a_ready,

    // Port B, read/write with byte enables
    input  logic                                    b_read,
    input  logic                                    b_write,
    input  logic [otter_mem_pkg::DATA_WIDTH/8-1:0]   b_byte_en,
    input  logic [otter_mem_pkg::MEM_ADDR_WIDTH-1:0] b_addr,
    input  logic [otter_mem_pkg::DATA_WIDTH-1:0]     b_wdata,
    output logic [otter_mem_pkg::DATA_WIDTH-1:0]     b_rdata,
    output logic                                    b_ready
);

    // Word storage
    logic [otter_mem_pkg::DATA_WIDTH-1:0] mem [0:otter_mem_pkg::MEM_NUM_WORDS-1];

    // Request accepted this cycle on each port
    logic a_go;
    logic b_go_rd;
    logic b_go_wr;

    // Held request is ignored while its ready is up
    assign a_go    = a_read & ~a_ready;
    assign b_go_rd = b_read & ~b_ready;
    // Read wins over a write in the same cycle
    assign b_go_wr = b_write & ~b_ready & ~b_read;

    //////////////////////////////////////////////////////////////////////
    // Ready flags
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge A_clk or negedge rst_n) begin
        if (!rst_n) begin
            a_ready <= 1'b0;
            b_ready <= 1'b0;
        end else begin
            // One-cycle pulse per accepted request
            a_ready <= a_go;
            b_ready <= b_go_rd | b_go_wr;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Array access
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge A_clk) begin
        // Word index drops the byte offset
        if (a_go) begin
            a_rdata <= mem[a_addr[otter_mem_pkg::MEM_ADDR_WIDTH-1:2]];
        end
        if (b_go_rd) begin
            b_rdata <= mem[b_addr[otter_mem_pkg::MEM_ADDR_WIDTH-1:2]];
        end else if (b_go_wr) begin
            // Only enabled byte lanes change
            for (int i = 0; i < otter_mem_pkg::DATA_WIDTH / 8; i++) begin
                if (b_byte_en[i]) begin
                    mem[b_addr[otter_mem_pkg::MEM_ADDR_WIDTH-1:2]][8*i +: 8] <=
                        b_wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

/* design/axil_mem_slave.sv */
`timescale 1ns/10ps

module axil_mem_slave (
    input  logic                                    A_clk,
    input  logic                                    rst_n,

    // AXI4-Lite write address
    input  logic [otter_mem_pkg::AXI_ADDR_WIDTH-1:0] awaddr,
    input  logic                                    awvalid,
    output logic                                    awready,

    // AXI4-Lite write data
    input  logic [otter_mem_pkg::DATA_WIDTH-1:0]     wdata,
    input  logic [otter_mem_pkg::DATA_WIDTH/8-1:0]   wstrb,
    input  logic                                    wvalid,
    output logic                                    wready,

    // AXI4-Lite write response
    output otter_mem_pkg::axi_resp_e                bresp,
    output logic                                    bvalid,
    input  logic                                    bready,

    // AXI4-Lite read address
    input  logic [otter_mem_pkg::AXI_ADDR_WIDTH-1:0] araddr,
    input  logic                                    arvalid,
    output logic                                    arready,

    // AXI4-Lite read data
    output logic [otter_mem_pkg::DATA_WIDTH-1:0]     rdata,
    output otter_mem_pkg::axi_resp_e                rresp,
    output logic                                    rvalid,
    input  logic                                    rready,

    // SRAM port B
    input  logic [otter_mem_pkg::DATA_WIDTH-1:0]     b_rdata,
    input  logic                                    b_ready,
    output logic                                    b_read,
    output logic                                    b_write,
    output logic [otter_mem_pkg::DATA_WIDTH/8-1:0]   b_byte_en,
    output logic [otter_mem_pkg::MEM_ADDR_WIDTH-1:0] b_addr,
    output logic [otter_mem_pkg::DATA_WIDTH-1:0]     b_wdata
);

    otter_mem_pkg::axil_state_e state;

    // Latched result of the window decode
    logic addr_err;

    // Transaction start conditions
    logic ar_take;
    logic aw_take;
    logic ar_in_win;
    logic aw_in_win;

    // Read first, write needs both address and data present
    assign ar_take = (state == otter_mem_pkg::st_idle) & arvalid;
    assign aw_take = (state == otter_mem_pkg::st_idle) & ~arvalid & awvalid & wvalid;

    // Window is the low MEM_ADDR_WIDTH bits, upper bits must be zero
    assign ar_in_win =
        (araddr[otter_mem_pkg::AXI_ADDR_WIDTH-1:otter_mem_pkg::MEM_ADDR_WIDTH] == '0);
    assign aw_in_win =
        (awaddr[otter_mem_pkg::AXI_ADDR_WIDTH-1:otter_mem_pkg::MEM_ADDR_WIDTH] == '0);

    //////////////////////////////////////////////////////////////////////
    // Control FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge A_clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= otter_mem_pkg::st_idle;
            arready  <= 1'b0;
            awready  <= 1'b0;
            wready   <= 1'b0;
            rvalid   <= 1'b0;
            bvalid   <= 1'b0;
            rresp    <= otter_mem_pkg::resp_okay;
            bresp    <= otter_mem_pkg::resp_okay;
            b_read   <= 1'b0;
            b_write  <= 1'b0;
            addr_err <= 1'b0;
        end else begin
            // Address ready flags only pulse
            arready <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;

            case (state)
                otter_mem_pkg::st_idle: begin
                    if (ar_take) begin
                        // Handshake lands next cycle, memory read starts with it
                        arready  <= 1'b1;
                        b_read   <= ar_in_win;
                        addr_err <= ~ar_in_win;
                        state    <= otter_mem_pkg::st_read;
                    end else if (aw_take) begin
                        // AW and W accepted together
                        awready  <= 1'b1;
                        wready   <= 1'b1;
                        b_write  <= aw_in_win;
                        addr_err <= ~aw_in_win;
                        state    <= otter_mem_pkg::st_write;
                    end
                end

                otter_mem_pkg::st_read: begin
                    if (addr_err) begin
                        // Out of window, answer without touching memory
                        rvalid <= 1'b1;
                        rresp  <= otter_mem_pkg::resp_slverr;
                        state  <= otter_mem_pkg::st_rresp;
                    end else if (b_ready) begin
                        b_read <= 1'b0;
                        rvalid <= 1'b1;
                        rresp  <= otter_mem_pkg::resp_okay;
                        state  <= otter_mem_pkg::st_rresp;
                    end
                end

                otter_mem_pkg::st_write: begin
                    if (addr_err) begin
                        bvalid <= 1'b1;
                        bresp  <= otter_mem_pkg::resp_slverr;
                        state  <= otter_mem_pkg::st_bresp;
                    end else if (b_ready) begin
                        // Data already in memory at this point
                        b_write <= 1'b0;
                        bvalid  <= 1'b1;
                        bresp   <= otter_mem_pkg::resp_okay;
                        state   <= otter_mem_pkg::st_bresp;
                    end
                end

                // Hold response until master takes it
                otter_mem_pkg::st_rresp: begin
                    if (rready) begin
                        rvalid <= 1'b0;
                        state  <= otter_mem_pkg::st_idle;
                    end
                end

                otter_mem_pkg::st_bresp: begin
                    if (bready) begin
                        bvalid <= 1'b0;
                        state  <= otter_mem_pkg::st_idle;
                    end
                end

                default: state <= otter_mem_pkg::st_idle;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Address, data and read return
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge A_clk) begin
        // AXI keeps these stable until the handshake, so early capture is safe
        if (ar_take) begin
            b_addr <= araddr[otter_mem_pkg::MEM_ADDR_WIDTH-1:0];
        end else if (aw_take) begin
            b_addr    <= awaddr[otter_mem_pkg::MEM_ADDR_WIDTH-1:0];
            b_wdata   <= wdata;
            b_byte_en <= wstrb;
        end

        // Error reads return zero
        if (state == otter_mem_pkg::st_read) begin
            if (addr_err) begin
                rdata <= '0;
            end else if (b_ready) begin
                rdata <= b_rdata;
            end
        end
    end

endmodule

/* design/ifetch_port.sv */
`timescale 1ns/10ps

module ifetch_port (
    input  logic                                    A_clk,
    input  logic                                    rst_n,

    // Fetch stage side
    input  logic                                    fetch_req,
    input  logic [otter_mem_pkg::DATA_WIDTH-1:0]     fetch_addr,
    output logic [otter_mem_pkg::DATA_WIDTH-1:0]     fetch_instr,
    output logic                                    fetch_valid,
    output logic                                    fetch_fault,

    // SRAM port A
    input  logic [otter_mem_pkg::DATA_WIDTH-1:0]     a_rdata,
    input  logic                                    a_ready,
    output logic                                    a_read,
    output logic [otter_mem_pkg::MEM_ADDR_WIDTH-1:0] a_addr
);

    // Memory read outstanding
    logic busy;

    // New request to act on this cycle
    logic take;
    logic aligned;

    // Held request is not seen again while busy or just faulted
    assign take    = fetch_req & ~busy & ~fetch_fault;
    assign aligned = (fetch_addr[1:0] == 2'b00);

    // Request drops in the cycle its ready arrives
    assign a_read = busy & ~a_ready;

    // Memory answer goes straight back to the core
    assign fetch_valid = a_ready;
    assign fetch_instr = a_rdata;

    //////////////////////////////////////////////////////////////////////
    // Request tracking
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge A_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy        <= 1'b0;
            fetch_fault <= 1'b0;
        end else begin
            // Fault is a single pulse
            fetch_fault <= take & ~aligned;
            if (take && aligned) begin
                busy <= 1'b1;
            end else if (a_ready) begin
                busy <= 1'b0;
            end
        end
    end

    // Upper address bits dropped, fetches wrap into the window
    always_ff @(posedge A_clk) begin
        if (take && aligned) begin
            a_addr <= fetch_addr[otter_mem_pkg::MEM_ADDR_WIDTH-1:0];
        end
    end

endmodule

/* design/otter_mem_subsystem.sv */
`timescale 1ns/10ps

module otter_mem_subsystem (
    input  logic                                    A_clk,
    input  logic                                    rst_n,

    // Instruction fetch
    input  logic                                    fetch_req,
    input  logic [otter_mem_pkg::DATA_WIDTH-1:0]     fetch_addr,
    output logic [otter_mem_pkg::DATA_WIDTH-1:0]     fetch_instr,
    output logic                                    fetch_valid,
    output logic                                    fetch_fault,

    // AXI4-Lite data port
    input  logic [otter_mem_pkg::AXI_ADDR_WIDTH-1:0] awaddr,
    input  logic                                    awvalid,
    output logic                                    awready,
    input  logic [otter_mem_pkg::DATA_WIDTH-1:0]     wdata,
    input  logic [otter_mem_pkg::DATA_WIDTH/8-1:0]   wstrb,
    input  logic                                    wvalid,
    output logic                                    wready,
    output otter_mem_pkg::axi_resp_e                bresp,
    output logic                                    bvalid,
    input  logic                                    bready,
    input  logic [otter_mem_pkg::AXI_ADDR_WIDTH-1:0] araddr,
    input  logic                                    arvalid,
    output logic                                    arready,
    output logic [otter_mem_pkg::DATA_WIDTH-1:0]     rdata,
    output otter_mem_pkg::axi_resp_e                rresp,
    output logic                                    rvalid,
    input  logic                                    rready
);

    // Port A, fetch side
    logic                                    a_read;
    logic [otter_mem_pkg::MEM_ADDR_WIDTH-1:0] a_addr;
    logic [otter_mem_pkg::DATA_WIDTH-1:0]     a_rdata;
    logic                                    a_ready;

    // Port B, AXI side
    logic                                    b_read;
    logic                                    b_write;
    logic [otter_mem_pkg::DATA_WIDTH/8-1:0]   b_byte_en;
    logic [otter_mem_pkg::MEM_ADDR_WIDTH-1:0] b_addr;
    logic [otter_mem_pkg::DATA_WIDTH-1:0]     b_wdata;
    logic [otter_mem_pkg::DATA_WIDTH-1:0]     b_rdata;
    logic                                    b_ready;

    //////////////////////////////////////////////////////////////////////
    // Fetch front end
    //////////////////////////////////////////////////////////////////////

    ifetch_port u_ifetch_port (
        .A_clk       (A_clk),
        .rst_n       (rst_n),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_instr (fetch_instr),
        .fetch_valid (fetch_valid),
        .fetch_fault (fetch_fault),
        .a_rdata     (a_rdata),
        .a_ready     (a_ready),
        .a_read      (a_read),
        .a_addr      (a_addr)
    );

    //////////////////////////////////////////////////////////////////////
    // AXI4-Lite slave
    //////////////////////////////////////////////////////////////////////

    axil_mem_slave u_axil_mem_slave (
        .A_clk     (A_clk),
        .rst_n     (rst_n),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .b_rdata   (b_rdata),
        .b_ready   (b_ready),
        .b_read    (b_read),
        .b_write   (b_write),
        .b_byte_en (b_byte_en),
        .b_addr    (b_addr),
        .b_wdata   (b_wdata)
    );

    //////////////////////////////////////////////////////////////////////
    // Shared memory
    //////////////////////////////////////////////////////////////////////

    sram u_sram (
        .A_clk     (A_clk),
        .rst_n     (rst_n),
        .a_read    (a_read),
        .a_addr    (a_addr),
        .a_rdata   (a_rdata),
        .a_ready   (a_ready),
        .b_read    (b_read),
        .b_write   (b_write),
        .b_byte_en (b_byte_en),
        .b_addr    (b_addr),
        .b_wdata   (b_wdata),
        .b_rdata   (b_rdata),
        .b_ready   (b_ready)
    );

endmodule

/* verification/tb_otter_mem_subsystem.sv */
`timescale 1ns/10ps

module tb_otter_mem_subsystem;

    localparam int CLK_PERIOD = 100;
    localparam logic [31:0] SEED = 32'h704368a8;
    // AXI and fetch transactions over all tests
    localparam int NUM_TXN = 49;
    // Cycles a response is held under back-pressure
    localparam int HOLD_CYCLES = 6;

    logic A_clk;
    logic rst_n;

    // Fetch side
    logic                                    fetch_req;
    logic [otter_mem_pkg::DATA_WIDTH-1:0]     fetch_addr;
    logic [otter_mem_pkg::DATA_WIDTH-1:0]     fetch_instr;
    logic                                    fetch_valid;
    logic                                    fetch_fault;

    // AXI4-Lite side
    logic [otter_mem_pkg::AXI_ADDR_WIDTH-1:0] awaddr;
    logic                                    awvalid;
    logic                                    awready;
    logic [otter_mem_pkg::DATA_WIDTH-1:0]     wdata;
    logic [otter_mem_pkg::DATA_WIDTH/8-1:0]   wstrb;
    logic                                    wvalid;
    logic                                    wready;
    otter_mem_pkg::axi_resp_e                bresp;
    logic                                    bvalid;
    logic                                    bready;
    logic [otter_mem_pkg::AXI_ADDR_WIDTH-1:0] araddr;
    logic                                    arvalid;
    logic                                    arready;
    logic [otter_mem_pkg::DATA_WIDTH-1:0]     rdata;
    otter_mem_pkg::axi_resp_e                rresp;
    logic                                    rvalid;
    logic                                    rready;

    // Shadow of the SRAM contents
    // Updated on every accepted write
    logic [otter_mem_pkg::DATA_WIDTH-1:0] shadow [0:otter_mem_pkg::MEM_NUM_WORDS-1];
    // In-window addresses known to hold defined data
    logic [31:0] written [$];

    int error_count;
    int check_count;

    otter_mem_subsystem UUT (.*);

    initial begin
        A_clk = 1'b0;
        forever #(CLK_PERIOD / 2) A_clk = ~A_clk;
    end

    // Watchdog
    initial begin
        #(CLK_PERIOD * (NUM_TXN * 20 + 100));
        $display("Run timed out, a handshake never completed");
        $display("*** TEST FAILED ***");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Compare tasks and helpers
    //////////////////////////////////////////////////////////////////////

    task automatic check_word(input logic [otter_mem_pkg::DATA_WIDTH-1:0] got,
                              input logic [otter_mem_pkg::DATA_WIDTH-1:0] exp,
                              input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error at %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_resp(input otter_mem_pkg::axi_resp_e got,
                              input otter_mem_pkg::axi_resp_e exp,
                              input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error at %0t: %s, got %s, expected %s",
                     $time, what, got.name(), exp.name());
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error at %0t: %s, got %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Random word-aligned address inside the window
    function automatic logic [31:0] rand_window_addr();
        logic [31:0] r;
        r = $urandom;
        return r & (otter_mem_pkg::MEM_SIZE_BYTES - 4);
    endfunction

    function automatic int word_index(input logic [31:0] addr);
        return int'(addr[otter_mem_pkg::MEM_ADDR_WIDTH-1:2]);
    endfunction

    // Byte lanes with strobe set take the new data
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] strb);
        logic [31:0] result;
        result = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Bus tasks
    //////////////////////////////////////////////////////////////////////

    // AW and W presented together with bready high
    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb,
                             output otter_mem_pkg::axi_resp_e resp);
        @(posedge A_clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= strb;
        wvalid  <= 1'b1;
        @(posedge A_clk);
        while (!(awready && wready)) @(posedge A_clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        @(posedge A_clk);
        while (!bvalid) @(posedge A_clk);
        resp = bresp;
    endtask

    task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
                            output otter_mem_pkg::axi_resp_e resp);
        @(posedge A_clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        @(posedge A_clk);
        while (!arready) @(posedge A_clk);
        arvalid <= 0;
        @(posedge A_clk);
        while (!rvalid) @(posedge A_clk);
        data = rdata;
        resp = rresp;
    endtask

    // Latency counts edges from the one that first sees fetch_req
    task automatic fetch(input logic [31:0] addr, output logic [31:0] instr,
                         output logic valid_seen, output logic fault_seen,
                         output int latency);
        @(posedge A_clk);
        fetch_req  <= 1'b1;
        fetch_addr <= addr;
        @(posedge A_clk);
        latency = 0;
        while (!fetch_valid && !fetch_fault) begin
            @(posedge A_clk);
            latency++;
        end
        valid_seen = fetch_valid;
        fault_seen = fetch_fault;
        instr      = fetch_instr;
        fetch_req <= 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_full_word();
        logic [31:0] addr;
        logic [31:0] data;
        otter_mem_pkg::axi_resp_e resp;
        for (int i = 0; i < 8; i++) begin
            addr = rand_window_addr();
            data = $urandom;
            axi_write(addr, data, 4'hf, resp);
            check_resp(resp, otter_mem_pkg::resp_okay, $sformatf("bresp at %h", addr));
            shadow[word_index(addr)] = data;
            written.push_back(addr);
        end
        foreach (written[i]) begin
            axi_read(written[i], data, resp);
            check_resp(resp, otter_mem_pkg::resp_okay, $sformatf("rresp at %h", written[i]));
            check_word(data, shadow[word_index(written[i])],
                       $sformatf("full word read at %h", written[i]));
        end
    endtask

    task automatic test_partial_strobe();
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0] strb;
        otter_mem_pkg::axi_resp_e resp;
        for (int i = 0; i < 8; i++) begin
            addr = written[i];
            data = $urandom;
            // Never all lanes and never none
            strb = 4'($urandom % 14 + 1);
            axi_write(addr, data, strb, resp);
            check_resp(resp, otter_mem_pkg::resp_okay, $sformatf("partial bresp at %h", addr));
            shadow[word_index(addr)] = merge_bytes(shadow[word_index(addr)], data, strb);
            axi_read(addr, data, resp);
            check_word(data, shadow[word_index(addr)],
                       $sformatf("strobe %b merge at %h", strb, addr));
        end
    endtask

    task automatic test_shared_fetch();
        logic [31:0] addr;
        logic [31:0] data;
        logic valid_seen;
        logic fault_seen;
        int latency;
        otter_mem_pkg::axi_resp_e resp;
        for (int i = 0; i < 4; i++) begin
            addr = rand_window_addr();
            data = $urandom;
            axi_write(addr, data, 4'hf, resp);
            shadow[word_index(addr)] = data;
            written.push_back(addr);
            fetch(addr, data, valid_seen, fault_seen, latency);
            check_flag(valid_seen, 1'b1, $sformatf("fetch_valid at %h", addr));
            check_flag(fault_seen, 1'b0, $sformatf("fetch_fault at %h", addr));
            check_word(latency, 2, $sformatf("fetch latency at %h", addr));
            check_word(data, shadow[word_index(addr)], $sformatf("fetched word at %h", addr));
        end
    endtask

    task automatic test_out_of_window();
        logic [31:0] addr;
        logic [31:0] bad_addr;
        logic [31:0] data;
        otter_mem_pkg::axi_resp_e resp;
        // Low bits alias a live word so a stray write would show up
        addr = written[0];
        bad_addr = addr | 32'h8000_0000 | (32'($urandom) << otter_mem_pkg::MEM_ADDR_WIDTH);
        axi_write(bad_addr, ~shadow[word_index(addr)], 4'hf, resp);
        check_resp(resp, otter_mem_pkg::resp_slverr, $sformatf("bresp at %h", bad_addr));
        axi_read(bad_addr, data, resp);
        check_resp(resp, otter_mem_pkg::resp_slverr, $sformatf("rresp at %h", bad_addr));
        check_word(data, 32'h0, $sformatf("error read data at %h", bad_addr));
        axi_read(addr, data, resp);
        check_resp(resp, otter_mem_pkg::resp_okay, $sformatf("rresp at %h", addr));
        check_word(data, shadow[word_index(addr)], $sformatf("word after error at %h", addr));
    endtask

    task automatic test_misaligned_fetch();
        logic [31:0] addr;
        logic [31:0] instr;
        logic valid_seen;
        logic fault_seen;
        int latency;
        for (int off = 1; off < 4; off++) begin
            addr = written[off] | 32'(off);
            fetch(addr, instr, valid_seen, fault_seen, latency);
            check_flag(fault_seen, 1'b1, $sformatf("fetch_fault at %h", addr));
            check_flag(valid_seen, 1'b0, $sformatf("fetch_valid at %h", addr));
            check_word(latency, 1, $sformatf("fault latency at %h", addr));
            // No late valid from a memory access
            repeat (3) begin
                @(posedge A_clk);
                check_flag(fetch_valid, 1'b0, $sformatf("late fetch_valid at %h", addr));
            end
        end
    endtask

    task automatic test_back_pressure();
        logic [31:0] rd_addr;
        logic [31:0] wr_addr;
        logic [31:0] wr_data;
        logic [31:0] held_data;
        otter_mem_pkg::axi_resp_e held_resp;
        rd_addr = written[1];
        wr_addr = rand_window_addr();
        wr_data = $urandom;

        // Read held with rready low while a write waits behind it
        @(posedge A_clk);
        rready  <= 1'b0;
        bready  <= 1'b0;
        araddr  <= rd_addr;
        arvalid <= 1'b1;
        @(posedge A_clk);
        while (!arready) @(posedge A_clk);
        arvalid <= 1'b0;
        awaddr  <= wr_addr;
        awvalid <= 1'b1;
        wdata   <= wr_data;
        wstrb   <= 4'hf;
        wvalid  <= 1'b1;
        @(posedge A_clk);
        while (!rvalid) begin
            check_flag(awready, 1'b0, "awready during read");
            check_flag(wready, 1'b0, "wready during read");
            @(posedge A_clk);
        end
        held_data = rdata;
        held_resp = rresp;
        check_word(held_data, shadow[word_index(rd_addr)], "held read data");
        check_resp(held_resp, otter_mem_pkg::resp_okay, "held rresp");
        repeat (HOLD_CYCLES) begin
            @(posedge A_clk);
            check_flag(rvalid, 1'b1, "rvalid under back-pressure");
            check_word(rdata, held_data, "rdata under back-pressure");
            check_resp(rresp, held_resp, "rresp under back-pressure");
            check_flag(awready, 1'b0, "awready while rvalid held");
            check_flag(wready, 1'b0, "wready while rvalid held");
        end
        rready <= 1'b1;

        // Queued write goes through and its bvalid is held
        @(posedge A_clk);
        while (!(awready && wready)) @(posedge A_clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        shadow[word_index(wr_addr)] = wr_data;
        written.push_back(wr_addr);
        araddr  <= wr_addr;
        arvalid <= 1'b1;
        @(posedge A_clk);
        while (!bvalid) begin
            check_flag(arready, 1'b0, "arready during write");
            @(posedge A_clk);
        end
        held_resp = bresp;
        check_resp(held_resp, otter_mem_pkg::resp_okay, "held bresp");
        repeat (HOLD_CYCLES) begin
            @(posedge A_clk);
            check_flag(bvalid, 1'b1, "bvalid under back-pressure");
            check_resp(bresp, held_resp, "bresp under back-pressure");
            check_flag(arready, 1'b0, "arready while bvalid held");
        end
        bready <= 1'b1;

        // Pending read returns the new word
        @(posedge A_clk);
        while (!arready) @(posedge A_clk);
        arvalid <= 1'b0;
        @(posedge A_clk);
        while (!rvalid) @(posedge A_clk);
        check_resp(rresp, otter_mem_pkg::resp_okay, "rresp after back-pressure");
        check_word(rdata, shadow[word_index(wr_addr)], "read after back-pressure");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(SEED));
        error_count = 0;
        check_count = 0;
        rst_n       = 1'b0;
        fetch_req   = 1'b0;
        fetch_addr  = '0;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wstrb       = '0;
        wvalid      = 1'b0;
        bready      = 1'b1;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b1;

        repeat (10) @(posedge A_clk);
        rst_n <= 1'b1;

        test_full_word();
        test_partial_strobe();
        test_shared_fetch();
        test_out_of_window();
        test_misaligned_fetch();
        test_back_pressure();

        repeat (2) @(posedge A_clk);
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* otter_mem_subsystem.f */
design/otter_mem_pkg.sv
design/sram.sv
design/axil_mem_slave.sv
design/ifetch_port.sv
design/otter_mem_subsystem.sv
verification/tb_otter_mem_subsystem.sv

/* Bender.yml */
package:
  name: otter_mem_subsystem

sources:
  - design/otter_mem_pkg.sv
  - design/sram.sv
  - design/axil_mem_slave.sv
  - design/ifetch_port.sv
  - design/otter_mem_subsystem.sv
  - target: test
    files:
      - verification/tb_otter_mem_subsystem.sv
